// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert --timescale 1ns/1ps
TOP       := elink_tx_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides, not the exit code of the model
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
design/elink_pkg.sv
design/ecfg_elink.sv
design/etx_fifo.sv
design/etx_serializer.sv
design/elink_tx.sv
test/elink_tx_checker.sv
test/elink_tx_tb.sv

// ==== design/ecfg_elink.sv ====
`timescale 1ns/1ps

module ecfg_elink (
   input  logic                     clk,
   input  logic                     por_reset,          // hard reset
   input  logic                     txwr_access,        // one cycle strobe
   input  logic [elink_pkg::PW-1:0] txwr_packet,
   output logic                     txwr_gated_access,  // to tx fifo
   output logic                     etx_soft_reset,     // level
   output logic                     erx_soft_reset,     // level
   output logic [15:0]              clk_config,         // pll settings
   output logic [11:0]              chipid
);
   import elink_pkg::*;

   // decoded packet fields
   logic            mi_we;
   logic [31:0]     mi_addr;
   logic [31:0]     mi_din;
   logic [RFAW-1:0] mi_reg;

   // decode
   logic mi_en;
   logic ecfg_write;
   logic reset_write;
   logic clk_write;
   logic chipid_write;

   // config registers
   logic [1:0]  ecfg_reset_reg;
   logic [15:0] ecfg_clk_reg;
   logic [11:0] ecfg_chipid_reg;

   // ####################################################################
   // packet unpack
   // ####################################################################
   assign mi_we   = txwr_packet[WRITE_BIT];
   assign mi_addr = txwr_packet[DST_MSB:DST_LSB];
   assign mi_din  = txwr_packet[DATA_MSB:DATA_LSB];
   assign mi_reg  = mi_addr[RFAW+1:2];            // word index in window

   // ####################################################################
   // address decode
   // ####################################################################
   // window hit needs both our mesh id and the config group
   assign mi_en = txwr_access &
                  (mi_addr[31:20] == ELINK_ID) &
                  (mi_addr[10:8] == CFG_GROUP);

   assign ecfg_write = mi_en & mi_we;             // reads fall through

   assign reset_write  = ecfg_write & (mi_reg == E_RESET);
   assign clk_write    = ecfg_write & (mi_reg == E_CLK);
   assign chipid_write = ecfg_write & (mi_reg == E_CHIPID);

   // only real register writes are swallowed,
   // unmapped indices still go out on the link
   assign txwr_gated_access = txwr_access &
                              ~(reset_write | clk_write | chipid_write);

   // ####################################################################
   // soft reset register
   // ####################################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         ecfg_reset_reg <= 2'b00;                  // both paths running
      end else if (reset_write) begin
         ecfg_reset_reg <= mi_din[1:0];
      end
   end

   assign etx_soft_reset = ecfg_reset_reg[0];      // flushes tx fifo + serializer
   assign erx_soft_reset = ecfg_reset_reg[1];      // rx side, not here

   // ####################################################################
   // clock config register
   // ####################################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         ecfg_clk_reg <= CLK_DEFAULT;
      end else if (clk_write) begin
         ecfg_clk_reg <= mi_din[15:0];
      end
   end

   assign clk_config = ecfg_clk_reg;               // no clock gen behind it

   // ####################################################################
   // chip id register
   // ####################################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         ecfg_chipid_reg <= DEFAULT_CHIPID;
      end else if (chipid_write) begin
         ecfg_chipid_reg <= mi_din[11:0];
      end
   end

   assign chipid = ecfg_chipid_reg;                // full 12 bits

   // ####################################################################
   // checks
   // ####################################################################
   // one access hits at most one register
   a_one_reg_write : assert property (
      @(posedge clk) disable iff (por_reset)
      $onehot0({reset_write, clk_write, chipid_write})
   ) else $error("ecfg_elink: more than one register write enable");

   // gate can only remove accesses, never create them
   a_gate_subset : assert property (
      @(posedge clk) disable iff (por_reset)
      txwr_gated_access |-> txwr_access
   ) else $error("ecfg_elink: gated access without source access");

endmodule

// ==== design/elink_pkg.sv ====
package elink_pkg;

   // ####################################################################
   // packet geometry
   // ####################################################################
   localparam int PW = 104;             // emesh packet width
   localparam int RFAW = 6;             // reg field addr width

   // field positions inside a packet
   localparam int WRITE_BIT = 0;        // write flag
   localparam int DMODE_LSB = 1;        // datamode
   localparam int DMODE_MSB = 2;
   localparam int CTRL_LSB = 3;         // ctrlmode
   localparam int CTRL_MSB = 6;
   localparam int DST_LSB = 8;          // dstaddr
   localparam int DST_MSB = 39;
   localparam int DATA_LSB = 40;        // write data
   localparam int DATA_MSB = 71;
   localparam int SRC_LSB = 72;         // srcaddr
   localparam int SRC_MSB = 103;

   // ####################################################################
   // config window
   // ####################################################################
   localparam logic [11:0] ELINK_ID = 12'h810;        // matched vs addr[31:20]
   localparam logic [2:0] CFG_GROUP = 3'h2;           // matched vs addr[10:8]
   localparam logic [11:0] DEFAULT_CHIPID = 12'h808;
   localparam logic [15:0] CLK_DEFAULT = 16'h573;     // all clocks on, slowest

   // register index, taken from addr[RFAW+1:2]
   typedef enum logic [RFAW-1:0] {
      E_RESET = 6'd0,                   // soft resets, bit0 tx / bit1 rx
      E_CLK = 6'd1,                     // clock config
      E_CHIPID = 6'd2                   // chip id
   } ecfg_reg_t;

   // ####################################################################
   // tx queue and serializer
   // ####################################################################
   localparam int FIFO_DEPTH = 4;       // packets
   localparam int FIFO_AW = 2;          // log2 of depth
   localparam int PKT_BYTES = 13;       // 104 / 8

   typedef enum logic {
      TX_IDLE,                          // waiting on fifo
      TX_SEND                           // frame up, shifting bytes
   } tx_state_t;

endpackage

// ==== design/elink_tx.sv ====
`timescale 1ns/1ps

module elink_tx (
   input  logic                     clk,
   input  logic                     por_reset,
   // write packets in
   input  logic                     txwr_access,
   input  logic [elink_pkg::PW-1:0] txwr_packet,
   output logic                     txwr_wait,
   // byte link out
   input  logic                     tx_wait,
   output logic                     tx_frame,
   output logic [7:0]               tx_data,
   // config outputs
   output logic                     etx_soft_reset,
   output logic                     erx_soft_reset,
   output logic [15:0]              clk_config,
   output logic [11:0]              chipid
);
   import elink_pkg::*;

   logic          txwr_gated_access;   // cfg writes removed
   logic          fifo_empty;
   logic          fifo_pop;
   logic [PW-1:0] fifo_packet;

   // config decode and register window
   ecfg_elink ecfg_elink_i (
      .clk               (clk),
      .por_reset         (por_reset),
      .txwr_access       (txwr_access),
      .txwr_packet       (txwr_packet),
      .txwr_gated_access (txwr_gated_access),
      .etx_soft_reset    (etx_soft_reset),
      .erx_soft_reset    (erx_soft_reset),
      .clk_config        (clk_config),
      .chipid            (chipid)
   );

   // packet queue, packet bypasses the gate as a wire
   etx_fifo etx_fifo_i (
      .clk               (clk),
      .por_reset         (por_reset),
      .etx_soft_reset    (etx_soft_reset),
      .txwr_gated_access (txwr_gated_access),
      .txwr_packet       (txwr_packet),
      .fifo_pop          (fifo_pop),
      .fifo_packet       (fifo_packet),
      .fifo_empty        (fifo_empty),
      .txwr_wait         (txwr_wait)
   );

   // byte serializer
   etx_serializer etx_serializer_i (
      .clk            (clk),
      .por_reset      (por_reset),
      .etx_soft_reset (etx_soft_reset),
      .fifo_empty     (fifo_empty),
      .fifo_packet    (fifo_packet),
      .tx_wait        (tx_wait),
      .fifo_pop       (fifo_pop),
      .tx_frame       (tx_frame),
      .tx_data        (tx_data)
   );

endmodule

// ==== design/etx_fifo.sv ====
`timescale 1ns/1ps

module etx_fifo (
   input  logic                     clk,
   input  logic                     por_reset,
   input  logic                     etx_soft_reset,     // flush + hold empty
   input  logic                     txwr_gated_access,  // write strobe
   input  logic [elink_pkg::PW-1:0] txwr_packet,
   input  logic                     fifo_pop,           // read strobe
   output logic [elink_pkg::PW-1:0] fifo_packet,        // head of queue
   output logic                     fifo_empty,
   output logic                     txwr_wait           // full level
);
   import elink_pkg::*;

   // storage
   logic [PW-1:0] mem [FIFO_DEPTH];

   // pointers, count has one extra bit for the full case
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;

   logic full;
   logic do_write;
   logic do_read;

   // ####################################################################
   // status
   // ####################################################################
   assign full       = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign fifo_empty = (count == '0);
   assign txwr_wait  = full;                    // back-pressure to source

   // writes dropped when full or while flushing
   assign do_write = txwr_gated_access & ~full & ~etx_soft_reset;
   assign do_read  = fifo_pop & ~fifo_empty;

   // ####################################################################
   // pointer and count
   // ####################################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (etx_soft_reset) begin
         wr_ptr <= '0;                          // flush, contents left stale
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;            // wraps at depth
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // none, or both at once
         endcase
      end
   end

   // ####################################################################
   // storage array
   // ####################################################################
   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[wr_ptr] <= txwr_packet;
      end
   end

   assign fifo_packet = mem[rd_ptr];            // first word fall through

   // ####################################################################
   // checks
   // ####################################################################
   // serializer must look at empty before popping
   a_no_pop_empty : assert property (
      @(posedge clk) disable iff (por_reset)
      fifo_pop |-> !fifo_empty
   ) else $error("etx_fifo: pop while empty");

   // source ignored txwr_wait, packet lost
   a_no_write_full : assert property (
      @(posedge clk) disable iff (por_reset)
      txwr_gated_access |-> !full
   ) else $error("etx_fifo: write while full, packet dropped");

endmodule

// ==== design/etx_serializer.sv ====
`timescale 1ns/1ps

module etx_serializer (
   input  logic                     clk,
   input  logic                     por_reset,
   input  logic                     etx_soft_reset,  // drop packet, go idle
   input  logic                     fifo_empty,
   input  logic [elink_pkg::PW-1:0] fifo_packet,     // queue head
   input  logic                     tx_wait,         // far end stall, level
   output logic                     fifo_pop,        // one cycle strobe
   output logic                     tx_frame,        // high for whole packet
   output logic [7:0]               tx_data
);
   import elink_pkg::*;

   tx_state_t state;

   logic [PW-1:0] pkt_reg;     // packet being sent
   logic [3:0]    byte_idx;    // bytes already sent
   logic [3:0]    byte_sel;    // byte lane within pkt_reg
   logic          last_byte;

   // ####################################################################
   // fifo side
   // ####################################################################
   // pop only from idle, so frame drops for a cycle between packets
   assign fifo_pop = (state == TX_IDLE) & ~fifo_empty & ~etx_soft_reset;

   // ####################################################################
   // byte select
   // ####################################################################
   assign byte_sel  = 4'(PKT_BYTES - 1) - byte_idx;       // msb first
   assign last_byte = (byte_idx == 4'(PKT_BYTES - 1));

   assign tx_frame = (state == TX_SEND);
   assign tx_data  = pkt_reg[{byte_sel, 3'b000} +: 8];    // lane * 8

   // ####################################################################
   // state machine
   // ####################################################################
   always_ff @(posedge clk or posedge por_reset) begin
      if (por_reset) begin
         state    <= TX_IDLE;
         byte_idx <= '0;
      end else if (etx_soft_reset) begin
         state    <= TX_IDLE;                 // current packet abandoned
         byte_idx <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               if (fifo_pop) begin
                  state    <= TX_SEND;
                  byte_idx <= '0;
               end
            end
            TX_SEND: begin
               if (!tx_wait) begin            // byte taken this edge
                  if (last_byte) begin
                     state    <= TX_IDLE;
                     byte_idx <= '0;
                  end else begin
                     byte_idx <= byte_idx + 1'b1;
                  end
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

   // holding register, loaded on pop
   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         pkt_reg <= fifo_packet;
      end
   end

   // ####################################################################
   // checks
   // ####################################################################
   // stall must freeze the link exactly, nothing lost or repeated
   a_wait_hold : assert property (
      @(posedge clk) disable iff (por_reset)
      tx_frame && tx_wait && !etx_soft_reset |=> tx_frame && $stable(tx_data)
   ) else $error("etx_serializer: tx_data moved during tx_wait");

endmodule

// ==== test/elink_tx_checker.sv ====
`timescale 1ns/1ps

module elink_tx_checker (
   input  logic                     clk,
   input  logic                     por_reset,
   input  logic                     txwr_access,
   input  logic [elink_pkg::PW-1:0] txwr_packet,
   input  logic                     txwr_wait,
   input  logic                     tx_wait,
   input  logic                     tx_frame,
   input  logic [7:0]               tx_data,
   input  logic                     etx_soft_reset,
   input  logic                     erx_soft_reset,
   input  logic [15:0]              clk_config,
   input  logic [11:0]              chipid,
   output int                       mismatch_count,
   output int                       other_count,
   output int                       pending,         // packets the model still owes
   output int                       frames_checked
);
   import elink_pkg::*;

   logic [1:0]    m_reset;          // model copies of the config regs
   logic [15:0]   m_clk;
   logic [11:0]   m_chipid;
   logic [PW-1:0] expect_q [$];     // forwarded packets, head may be on the link
   int            fifo_occ;         // dut fifo entries, loaded packet not counted
   logic          busy;             // serializer holds a packet
   int            sent;             // bytes of current frame taken
   logic [PW-1:0] frame_bits;       // frame assembled from tx_data
   int            n_mismatch;
   int            n_other;
   int            n_frames;

   task automatic check_value(input string name, input logic [PW-1:0] expected,
                              input logic [PW-1:0] got);
      if (got !== expected) begin
         $display("mismatch t=%0t %s expected %0h got %0h", $time, name, expected, got);
         n_mismatch++;
      end
   endtask

   // write that lands in one of the three registers
   function automatic logic reg_write(input logic [PW-1:0] pkt);
      logic [31:0]     a;
      logic [RFAW-1:0] idx;
      a   = pkt[DST_MSB:DST_LSB];
      idx = a[RFAW+1:2];
      return pkt[WRITE_BIT] && (a[31:20] == ELINK_ID) && (a[10:8] == CFG_GROUP) &&
             (idx == E_RESET || idx == E_CLK || idx == E_CHIPID);
   endfunction

   // ####################################################################
   // compare at each edge, then step the model
   // ####################################################################
   always @(posedge clk or posedge por_reset) begin
      logic [31:0] addr;
      logic [31:0] din;
      logic        cfg_wr;
      logic        gated;
      logic        pop;
      logic        wr;
      if (por_reset) begin
         m_reset  = 2'b00;                  // por defaults
         m_clk    = 16'h573;
         m_chipid = 12'h808;
         expect_q.delete();
         fifo_occ   = 0;
         busy       = 1'b0;
         sent       = 0;
         n_mismatch = 0;
         n_other    = 0;
         n_frames   = 0;
      end else begin
         check_value("clk_config", PW'(m_clk), PW'(clk_config));
         check_value("chipid", PW'(m_chipid), PW'(chipid));
         check_value("etx_soft_reset", PW'(m_reset[0]), PW'(etx_soft_reset));
         check_value("erx_soft_reset", PW'(m_reset[1]), PW'(erx_soft_reset));
         check_value("txwr_wait", PW'(fifo_occ == FIFO_DEPTH), PW'(txwr_wait));
         check_value("tx_frame", PW'(busy), PW'(tx_frame));
         addr   = txwr_packet[DST_MSB:DST_LSB];
         din    = txwr_packet[DATA_MSB:DATA_LSB];
         cfg_wr = txwr_access && reg_write(txwr_packet);
         gated  = txwr_access && !cfg_wr;   // everything else goes to the link
         if (m_reset[0]) begin               // tx flush, forwarded packets lost
            expect_q.delete();
            fifo_occ = 0;
            busy     = 1'b0;
            sent     = 0;
         end else begin
            pop = !busy && (fifo_occ > 0);   // pops only from idle
            wr  = gated && (fifo_occ < FIFO_DEPTH);
            if (busy && !tx_wait) begin       // byte taken this edge
               frame_bits = {frame_bits[PW-9:0], tx_data};
               sent++;
               if (sent == PKT_BYTES) begin
                  if (expect_q.size() == 0) begin
                     $display("t=%0t a frame was sent with no packet queued", $time);
                     n_other++;
                  end else begin
                     check_value("tx_data frame", expect_q.pop_front(), frame_bits);
                     n_frames++;
                  end
                  busy = 1'b0;
                  sent = 0;
               end
            end
            if (gated && !wr) begin
               $display("t=%0t an access arrived while the fifo was full", $time);
               n_other++;
            end
            if (wr) begin
               expect_q.push_back(txwr_packet);
            end
            if (pop) begin
               busy = 1'b1;
               sent = 0;
            end
            fifo_occ = fifo_occ + int'(wr) - int'(pop);
         end
         if (cfg_wr) begin                   // seen at the outputs next cycle
            case (addr[RFAW+1:2])
               E_RESET:  m_reset  = din[1:0];
               E_CLK:    m_clk    = din[15:0];
               E_CHIPID: m_chipid = din[11:0];
               default:  ;
            endcase
         end
      end
      mismatch_count <= n_mismatch;
      other_count    <= n_other;
      frames_checked <= n_frames;
      pending        <= expect_q.size();
   end

endmodule

// ==== test/elink_tx_tb.sv ====
`timescale 1ns/1ps

module elink_tx_tb;
   import elink_pkg::*;

   localparam int STIM_CYCLES = 2000;
   localparam int DRAIN_LIMIT = 3000;    // drain timeout, cycles

   logic          clk;
   logic          por_reset;
   logic          txwr_access;
   logic [PW-1:0] txwr_packet;
   logic          txwr_wait;
   logic          tx_wait;
   logic          tx_frame;
   logic [7:0]    tx_data;
   logic          etx_soft_reset;
   logic          erx_soft_reset;
   logic [15:0]   clk_config;
   logic [11:0]   chipid;

   int mismatch_count;
   int other_count;
   int pending;
   int frames_checked;
   int timeout_count;

   logic [31:0] rng;                     // xorshift state
   logic [31:0] r;
   int          wait_left;               // cycles left in this tx_wait stretch
   logic        wait_level;
   int          cycle;
   int          n;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;            // 20 ns
   end

   elink_tx elink_tx_i (
      .clk            (clk),
      .por_reset      (por_reset),
      .txwr_access    (txwr_access),
      .txwr_packet    (txwr_packet),
      .txwr_wait      (txwr_wait),
      .tx_wait        (tx_wait),
      .tx_frame       (tx_frame),
      .tx_data        (tx_data),
      .etx_soft_reset (etx_soft_reset),
      .erx_soft_reset (erx_soft_reset),
      .clk_config     (clk_config),
      .chipid         (chipid)
   );

   elink_tx_checker checker_i (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] next_random();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // ####################################################################
   // random packet, kind from k[3:0]
   // 0-2 reg write, 3-4 unmapped window index, 5-6 reg read, 7-11 other id
   // ####################################################################
   function automatic logic [PW-1:0] make_packet();
      logic [PW-1:0] pkt;
      logic [31:0]   k;
      logic [31:0]   addr;
      logic [5:0]    idx;
      k    = next_random();
      addr = next_random();
      pkt[SRC_MSB:SRC_LSB]   = next_random();
      pkt[DATA_MSB:DATA_LSB] = next_random();
      pkt[7:0] = k[31:24];               // write flag, modes random
      idx      = k[13:8];
      case (k[3:0])
         4'd0, 4'd1, 4'd2: begin
            idx = {4'd0, k[1:0]};
            pkt[WRITE_BIT] = 1'b1;
            if (k[1:0] == 2'd0) begin     // tx flush set on 1 of 8 reset writes
               pkt[DATA_LSB] = (k[18:16] == 3'd0);
            end
         end
         4'd3, 4'd4: begin
            if (idx < 6'd3) begin
               idx = idx + 6'd3;
            end
            pkt[WRITE_BIT] = 1'b1;
         end
         4'd5, 4'd6: begin
            idx = (k[9:8] == 2'd3) ? 6'd0 : {4'd0, k[9:8]};
            pkt[WRITE_BIT] = 1'b0;
         end
         default: ;
      endcase
      if (k[3:0] <= 4'd6) begin
         addr[31:20]     = ELINK_ID;
         addr[10:8]      = CFG_GROUP;
         addr[RFAW+1:2]  = idx;
      end else if (k[3:0] <= 4'd11 && addr[31:20] == ELINK_ID) begin
         addr[20] = ~addr[20];            // force a foreign id
      end
      pkt[DST_MSB:DST_LSB] = addr;
      return pkt;
   endfunction

   // ####################################################################
   // stimulus, drain, report
   // ####################################################################
   initial begin
      por_reset     = 1'b1;
      txwr_access   = 1'b0;
      txwr_packet   = '0;
      tx_wait       = 1'b0;
      rng           = 32'd23;
      wait_left     = 0;
      wait_level    = 1'b0;
      timeout_count = 0;
      repeat (4) @(posedge clk);
      por_reset <= 1'b0;
      for (cycle = 0; cycle < STIM_CYCLES; cycle++) begin
         @(posedge clk);
         if (wait_left == 0) begin        // new stretch, up to 64 cycles
            r          = next_random();
            wait_left  = 1 + int'(r[5:0]);
            wait_level = (r[9:8] == 2'd0);
         end
         wait_left = wait_left - 1;
         tx_wait  <= wait_level;
         r = next_random();
         // an access seen at this edge may fill the fifo, so none back to back
         if (!txwr_wait && !txwr_access && r[1:0] != 2'd0) begin
            txwr_access <= 1'b1;
            txwr_packet <= make_packet();
         end else begin
            txwr_access <= 1'b0;
         end
      end
      @(posedge clk);
      txwr_access <= 1'b0;
      tx_wait     <= 1'b0;
      n = 0;
      do begin                            // checker counts lag one edge
         @(posedge clk);
         n++;
      end while ((pending != 0 || tx_frame) && n < DRAIN_LIMIT);
      if (pending != 0 || tx_frame) begin
         $display("timeout: %0d packets still owed after %0d drain cycles", pending, n);
         timeout_count++;
      end
      @(posedge clk);                     // last counts from the checker
      $display("frames %0d, errors: mismatch %0d, other %0d, timeout %0d",
               frames_checked, mismatch_count, other_count, timeout_count);
      if (mismatch_count + other_count + timeout_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
